// File: verilog/stbuf_settings.svh
// Sizing constants for the L1 data cache store path.
// Include wherever a width or the strand count is needed; the package types build on these.

`ifndef STBUF_SETTINGS_SVH
`define STBUF_SETTINGS_SVH

// Hardware strands sharing the data cache, one store buffer entry each
`define STBUF_STRANDS 4

// Line address split as seen by the L1 and the L2
`define STBUF_TAG_WIDTH 20
`define STBUF_SET_WIDTH 6

// One cache line of payload and its byte enables
`define STBUF_LINE_BITS 512
`define STBUF_MASK_BITS 64

// Responses carrying this unit number belong to the store path
`define STBUF_UNIT_ID 2

`endif

// File: verilog/stbuf_pkg.sv
// Field types and the L2 request opcodes shared by the store path modules.
// Modules import this inside their body and use scoped names in their port lists.

`include "stbuf_settings.svh"

package stbuf_pkg;

	typedef logic [`STBUF_TAG_WIDTH-1:0] l1_tag_t;
	typedef logic [`STBUF_SET_WIDTH-1:0] l1_set_t;
	typedef logic [`STBUF_LINE_BITS-1:0] line_data_t;
	typedef logic [`STBUF_MASK_BITS-1:0] line_mask_t;

	typedef logic [$clog2(`STBUF_STRANDS)-1:0] strand_t;
	typedef logic [`STBUF_STRANDS-1:0] strand_mask_t;

	typedef logic [1:0] unit_t;

	// The L2 identifies this requester by a fixed unit number
	localparam unit_t STBUF_UNIT = unit_t'(`STBUF_UNIT_ID);

	typedef enum logic [2:0]
	{
		L2_OP_STORE      = 3'd1,
		L2_OP_FLUSH      = 3'd2,
		L2_OP_STORE_SYNC = 3'd5
	} l2_op_t;

endpackage

// File: verilog/issue_arbiter.sv
// Round-robin arbiter for store buffer issue.
// The priority pointer moves only when the caller takes the grant.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module issue_arbiter #(
	parameter int REQ_COUNT = `STBUF_STRANDS
)(
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic [REQ_COUNT-1:0] request_i,
	input  logic                 advance_i,
	output logic [REQ_COUNT-1:0] grant_o
);

	localparam int PTR_W = (REQ_COUNT > 1) ? $clog2(REQ_COUNT) : 1;

	logic [PTR_W-1:0] last_q;
	logic [PTR_W-1:0] next_idx;
	logic             found;
	int               pick;

	// Search circularly starting just past the last winner
	always_comb
	begin
		grant_o = '0;
		next_idx = last_q;
		found = 1'b0;
		for (int k = 1; k <= REQ_COUNT; k++)
		begin
			pick = (int'(last_q) + k) % REQ_COUNT;
			if (!found && request_i[pick])
			begin
				found = 1'b1;
				grant_o[pick] = 1'b1;
				next_idx = PTR_W'(pick);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		// Start with the last position so requester 0 wins first
		if (reset_i)
			last_q <= PTR_W'(REQ_COUNT - 1);
		else if (advance_i && found)
			last_q <= next_idx;
	end

endmodule

// File: verilog/l2_request_port.sv
// Issue side of the store buffer: picks a pending entry and presents it to the L2.
// The request is held as a level until pci_ack_i, then the port rests for a cycle.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module l2_request_port (
	input  logic                   clk,
	input  logic                   reset_i,
	input  stbuf_pkg::strand_mask_t entry_pending_i,
	input  stbuf_pkg::l1_tag_t     entry_tag_i [`STBUF_STRANDS],
	input  stbuf_pkg::l1_set_t     entry_set_i [`STBUF_STRANDS],
	input  stbuf_pkg::line_data_t  entry_data_i [`STBUF_STRANDS],
	input  stbuf_pkg::line_mask_t  entry_mask_i [`STBUF_STRANDS],
	input  stbuf_pkg::strand_mask_t entry_sync_i,
	input  stbuf_pkg::strand_mask_t entry_flush_i,
	output stbuf_pkg::strand_mask_t acked_o,
	output logic                   pci_valid_o,
	input  logic                   pci_ack_i,
	output stbuf_pkg::strand_t     pci_strand_o,
	output stbuf_pkg::l2_op_t      pci_op_o,
	output logic [`STBUF_TAG_WIDTH+`STBUF_SET_WIDTH-1:0] pci_address_o,
	output stbuf_pkg::line_data_t  pci_data_o,
	output stbuf_pkg::line_mask_t  pci_mask_o
);

	import stbuf_pkg::*;

	strand_mask_t grant;
	strand_t      grant_strand;
	logic         take_grant;

	// A new entry is only picked while no request is outstanding
	assign take_grant = !pci_valid_o && (grant != '0);

	issue_arbiter #(
		.REQ_COUNT(`STBUF_STRANDS)
	) u_issue_arbiter (
		.clk       (clk),
		.reset_i   (reset_i),
		.request_i (entry_pending_i),
		.advance_i (take_grant),
		.grant_o   (grant)
	);

	always_comb
	begin
		grant_strand = '0;
		for (int i = 0; i < `STBUF_STRANDS; i++)
		begin
			if (grant[i])
				grant_strand = strand_t'(i);
		end
	end

	assign acked_o = (pci_valid_o && pci_ack_i) ? (strand_mask_t'(1) << pci_strand_o) : '0;

	always_ff @(posedge clk)
	begin
		if (reset_i)
			pci_valid_o <= 1'b0;
		else if (pci_valid_o && pci_ack_i)
			pci_valid_o <= 1'b0;
		else if (take_grant)
			pci_valid_o <= 1'b1;
	end

	// Request fields are captured once so they stay stable while the L2 stalls
	always_ff @(posedge clk)
	begin
		if (take_grant)
		begin
			pci_strand_o <= grant_strand;
			pci_address_o <= {entry_tag_i[grant_strand], entry_set_i[grant_strand]};
			pci_data_o <= entry_data_i[grant_strand];
			pci_mask_o <= entry_mask_i[grant_strand];
			if (entry_flush_i[grant_strand])
				pci_op_o <= L2_OP_FLUSH;
			else if (entry_sync_i[grant_strand])
				pci_op_o <= L2_OP_STORE_SYNC;
			else
				pci_op_o <= L2_OP_STORE;
		end
	end

endmodule

// File: verilog/sync_store_tracker.sv
// Response decode and synchronized store bookkeeping for each strand.
// The first sync attempt waits for the L2, the retry picks up the saved status.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module sync_store_tracker (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    cpi_valid_i,
	input  stbuf_pkg::unit_t        cpi_unit_i,
	input  stbuf_pkg::strand_t      cpi_strand_i,
	input  logic                    cpi_status_i,
	input  stbuf_pkg::strand_mask_t sync_req_i,
	output stbuf_pkg::strand_mask_t l2_done_mask_o,
	output stbuf_pkg::strand_mask_t sync_wake_o,
	output logic                    sync_rollback_o,
	output stbuf_pkg::strand_mask_t sync_result_o
);

	import stbuf_pkg::*;

	strand_mask_t sync_wait;
	strand_mask_t sync_complete;
	strand_mask_t sync_start;

	// Other units share the response bus, so filter on the unit number
	assign l2_done_mask_o = (cpi_valid_i && cpi_unit_i == STBUF_UNIT)
		? (strand_mask_t'(1) << cpi_strand_i) : '0;

	// A request without a saved result has to go to the L2 first
	assign sync_start = sync_req_i & ~sync_complete;
	assign sync_rollback_o = (sync_start != '0);

	assign sync_wake_o = l2_done_mask_o & sync_wait;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			sync_wait <= '0;
			sync_complete <= '0;
		end
		else
		begin
			sync_wait <= (sync_wait | sync_start) & ~l2_done_mask_o;
			// The retry consumes the result, clearing complete for the next sync store
			sync_complete <= (sync_complete | sync_wake_o) & ~sync_req_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			sync_result_o <= '0;
		else
		begin
			for (int i = 0; i < `STBUF_STRANDS; i++)
			begin
				if (sync_wake_o[i])
					sync_result_o[i] <= cpi_status_i;
			end
		end
	end

endmodule

// File: verilog/store_buffer.sv
// One pending store, flush or sync store per strand, with same-strand load bypass.
// Strands that find their entry busy are rolled back and resumed on the L2 response.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module store_buffer (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    dcache_store_i,
	input  logic                    dcache_flush_i,
	input  logic                    dcache_stbar_i,
	input  logic                    synchronized_i,
	input  stbuf_pkg::strand_t      strand_i,
	input  stbuf_pkg::l1_tag_t      requested_tag_i,
	input  stbuf_pkg::l1_set_t      requested_set_i,
	input  stbuf_pkg::line_data_t   store_data_i,
	input  stbuf_pkg::line_mask_t   store_mask_i,
	input  stbuf_pkg::strand_mask_t l2_done_mask_i,
	input  stbuf_pkg::strand_mask_t acked_i,
	input  stbuf_pkg::strand_mask_t sync_wake_i,
	input  stbuf_pkg::strand_mask_t sync_result_i,
	input  logic                    sync_rollback_i,
	input  logic                    cpi_update_i,
	output stbuf_pkg::line_data_t   data_o,
	output stbuf_pkg::line_mask_t   mask_o,
	output logic                    rollback_o,
	output stbuf_pkg::strand_mask_t store_resume_strands_o,
	output logic                    store_update_o,
	output stbuf_pkg::l1_set_t      store_update_set_o,
	output stbuf_pkg::strand_mask_t entry_pending_o,
	output stbuf_pkg::l1_tag_t      entry_tag_o [`STBUF_STRANDS],
	output stbuf_pkg::l1_set_t      entry_set_o [`STBUF_STRANDS],
	output stbuf_pkg::line_data_t   entry_data_o [`STBUF_STRANDS],
	output stbuf_pkg::line_mask_t   entry_mask_o [`STBUF_STRANDS],
	output stbuf_pkg::strand_mask_t entry_sync_o,
	output stbuf_pkg::strand_mask_t entry_flush_o,
	output stbuf_pkg::strand_mask_t sync_req_o
);

	import stbuf_pkg::*;

	strand_mask_t entry_valid;
	strand_mask_t entry_acked;
	strand_mask_t wait_strands;
	strand_mask_t retire;
	strand_mask_t strand_onehot;
	strand_mask_t enqueue_mask;
	l1_tag_t      entry_tag [`STBUF_STRANDS];
	l1_set_t      entry_set [`STBUF_STRANDS];
	line_data_t   entry_data [`STBUF_STRANDS];
	line_mask_t   entry_mask [`STBUF_STRANDS];
	line_data_t   bypass_data;
	line_mask_t   bypass_mask;
	logic         any_op;
	logic         collision;
	logic         buffer_full;
	logic         enqueue;
	logic         full_rollback_q;
	logic         sync_rollback_q;

	assign strand_onehot = strand_mask_t'(1) << strand_i;
	assign any_op = dcache_store_i || dcache_flush_i || dcache_stbar_i;
	assign retire = l2_done_mask_i & entry_valid;

	// An entry retiring this cycle frees its slot for the same strand at once
	assign collision = any_op && retire[strand_i];
	assign buffer_full = any_op && entry_valid[strand_i] && !collision;

	assign sync_req_o = (synchronized_i && dcache_store_i && !entry_valid[strand_i])
		? strand_onehot : '0;

	// A sync store with a saved result completes locally and is not queued again
	assign enqueue = (dcache_store_i || dcache_flush_i)
		&& (!entry_valid[strand_i] || collision)
		&& (!synchronized_i || sync_rollback_i);
	assign enqueue_mask = enqueue ? strand_onehot : '0;

	assign entry_pending_o = entry_valid & ~entry_acked;
	assign entry_tag_o = entry_tag;
	assign entry_set_o = entry_set;
	assign entry_data_o = entry_data;
	assign entry_mask_o = entry_mask;

	// Loads only see stores from their own strand
	always_comb
	begin
		bypass_data = '0;
		bypass_mask = '0;
		if (entry_valid[strand_i] && entry_tag[strand_i] == requested_tag_i
			&& entry_set[strand_i] == requested_set_i)
		begin
			bypass_data = entry_data[strand_i];
			bypass_mask = entry_mask[strand_i];
		end
	end

	// The response names a single strand, so the set comes from that entry
	always_comb
	begin
		store_update_set_o = '0;
		for (int i = 0; i < `STBUF_STRANDS; i++)
		begin
			if (l2_done_mask_i[i])
				store_update_set_o = entry_set[i];
		end
	end

	assign store_update_o = (l2_done_mask_i != '0) && cpi_update_i;

	assign rollback_o = full_rollback_q || sync_rollback_q;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			entry_valid <= '0;
			entry_acked <= '0;
			wait_strands <= '0;
			full_rollback_q <= 1'b0;
			sync_rollback_q <= 1'b0;
			store_resume_strands_o <= '0;
		end
		else
		begin
			entry_valid <= (entry_valid & ~retire) | enqueue_mask;
			entry_acked <= (entry_acked | acked_i) & ~retire & ~enqueue_mask;
			wait_strands <= (wait_strands & ~l2_done_mask_i)
				| (buffer_full ? strand_onehot : '0);
			full_rollback_q <= buffer_full;
			sync_rollback_q <= sync_rollback_i;
			// Delayed a cycle so the resume lands after the rollback took effect
			store_resume_strands_o <= (l2_done_mask_i & wait_strands) | sync_wake_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue)
		begin
			entry_tag[strand_i] <= requested_tag_i;
			entry_set[strand_i] <= requested_set_i;
			entry_data[strand_i] <= store_data_i;
			entry_mask[strand_i] <= store_mask_i;
			entry_sync_o[strand_i] <= synchronized_i;
			entry_flush_o[strand_i] <= dcache_flush_i;
		end

		// Sync status goes in bit 0 of every 32-bit word
		if (synchronized_i && dcache_store_i)
		begin
			mask_o <= '1;
			data_o <= {(`STBUF_LINE_BITS / 32){31'd0, sync_result_i[strand_i]}};
		end
		else
		begin
			mask_o <= bypass_mask;
			data_o <= bypass_data;
		end
	end

endmodule

// File: verilog/l2_store_path.sv
// Store path of the L1 data cache: store buffer, sync tracking and the L2 request port.
// Connects the L1 pipeline strobes to the L2 request and response buses.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module l2_store_path (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    dcache_store_i,
	input  logic                    dcache_flush_i,
	input  logic                    dcache_stbar_i,
	input  logic                    synchronized_i,
	input  stbuf_pkg::strand_t      strand_i,
	input  stbuf_pkg::l1_tag_t      requested_tag_i,
	input  stbuf_pkg::l1_set_t      requested_set_i,
	input  stbuf_pkg::line_data_t   store_data_i,
	input  stbuf_pkg::line_mask_t   store_mask_i,
	output stbuf_pkg::line_data_t   data_o,
	output stbuf_pkg::line_mask_t   mask_o,
	output logic                    rollback_o,
	output stbuf_pkg::strand_mask_t store_resume_strands_o,
	output logic                    store_update_o,
	output stbuf_pkg::l1_set_t      store_update_set_o,
	output logic                    pci_valid_o,
	input  logic                    pci_ack_i,
	output stbuf_pkg::strand_t      pci_strand_o,
	output stbuf_pkg::l2_op_t       pci_op_o,
	output logic [`STBUF_TAG_WIDTH+`STBUF_SET_WIDTH-1:0] pci_address_o,
	output stbuf_pkg::line_data_t   pci_data_o,
	output stbuf_pkg::line_mask_t   pci_mask_o,
	input  logic                    cpi_valid_i,
	input  stbuf_pkg::unit_t        cpi_unit_i,
	input  stbuf_pkg::strand_t      cpi_strand_i,
	input  logic                    cpi_status_i,
	input  logic                    cpi_update_i
);

	import stbuf_pkg::*;

	strand_mask_t l2_done_mask;
	strand_mask_t sync_wake;
	strand_mask_t sync_result;
	strand_mask_t sync_req;
	strand_mask_t entry_pending;
	strand_mask_t entry_sync;
	strand_mask_t entry_flush;
	strand_mask_t acked_mask;
	logic         sync_rollback;
	l1_tag_t      entry_tag [`STBUF_STRANDS];
	l1_set_t      entry_set [`STBUF_STRANDS];
	line_data_t   entry_data [`STBUF_STRANDS];
	line_mask_t   entry_mask [`STBUF_STRANDS];

	sync_store_tracker u_sync_store_tracker (
		.clk             (clk),
		.reset_i         (reset_i),
		.cpi_valid_i     (cpi_valid_i),
		.cpi_unit_i      (cpi_unit_i),
		.cpi_strand_i    (cpi_strand_i),
		.cpi_status_i    (cpi_status_i),
		.sync_req_i      (sync_req),
		.l2_done_mask_o  (l2_done_mask),
		.sync_wake_o     (sync_wake),
		.sync_rollback_o (sync_rollback),
		.sync_result_o   (sync_result)
	);

	store_buffer u_store_buffer (
		.clk                    (clk),
		.reset_i                (reset_i),
		.dcache_store_i         (dcache_store_i),
		.dcache_flush_i         (dcache_flush_i),
		.dcache_stbar_i         (dcache_stbar_i),
		.synchronized_i         (synchronized_i),
		.strand_i               (strand_i),
		.requested_tag_i        (requested_tag_i),
		.requested_set_i        (requested_set_i),
		.store_data_i           (store_data_i),
		.store_mask_i           (store_mask_i),
		.l2_done_mask_i         (l2_done_mask),
		.acked_i                (acked_mask),
		.sync_wake_i            (sync_wake),
		.sync_result_i          (sync_result),
		.sync_rollback_i        (sync_rollback),
		.cpi_update_i           (cpi_update_i),
		.data_o                 (data_o),
		.mask_o                 (mask_o),
		.rollback_o             (rollback_o),
		.store_resume_strands_o (store_resume_strands_o),
		.store_update_o         (store_update_o),
		.store_update_set_o     (store_update_set_o),
		.entry_pending_o        (entry_pending),
		.entry_tag_o            (entry_tag),
		.entry_set_o            (entry_set),
		.entry_data_o           (entry_data),
		.entry_mask_o           (entry_mask),
		.entry_sync_o           (entry_sync),
		.entry_flush_o          (entry_flush),
		.sync_req_o             (sync_req)
	);

	l2_request_port u_l2_request_port (
		.clk             (clk),
		.reset_i         (reset_i),
		.entry_pending_i (entry_pending),
		.entry_tag_i     (entry_tag),
		.entry_set_i     (entry_set),
		.entry_data_i    (entry_data),
		.entry_mask_i    (entry_mask),
		.entry_sync_i    (entry_sync),
		.entry_flush_i   (entry_flush),
		.acked_o         (acked_mask),
		.pci_valid_o     (pci_valid_o),
		.pci_ack_i       (pci_ack_i),
		.pci_strand_o    (pci_strand_o),
		.pci_op_o        (pci_op_o),
		.pci_address_o   (pci_address_o),
		.pci_data_o      (pci_data_o),
		.pci_mask_o      (pci_mask_o)
	);

endmodule

// File: verif/l2_store_path_assert.sv
// Protocol and consistency assertions for the store path, bound into the top level.
// Counts its own failures so the testbench can fold them into the result.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module l2_store_path_assert (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    pci_valid_i,
	input  logic                    pci_ack_i,
	input  stbuf_pkg::strand_t      pci_strand_i,
	input  stbuf_pkg::l2_op_t       pci_op_i,
	input  logic [`STBUF_TAG_WIDTH+`STBUF_SET_WIDTH-1:0] pci_address_i,
	input  stbuf_pkg::line_data_t   pci_data_i,
	input  stbuf_pkg::line_mask_t   pci_mask_i,
	input  stbuf_pkg::strand_mask_t l2_done_mask_i,
	input  stbuf_pkg::strand_mask_t entry_valid_i,
	input  logic                    rollback_i
);

	int fail_count = 0;

	// A request waiting for the L2 keeps every field unchanged
	request_held: assert property (@(posedge clk) disable iff (reset_i)
		pci_valid_i && !pci_ack_i |=> pci_valid_i && $stable(pci_strand_i)
		&& $stable(pci_op_i) && $stable(pci_address_i) && $stable(pci_data_i)
		&& $stable(pci_mask_i))
	else
	begin
		fail_count++;
		$error("L2 request dropped or changed before its acknowledge");
	end

	response_has_entry: assert property (@(posedge clk) disable iff (reset_i)
		(l2_done_mask_i != '0) |-> ((l2_done_mask_i & entry_valid_i) != '0))
	else
	begin
		fail_count++;
		$error("L2 response arrived for an empty entry");
	end

	quiet_in_reset: assert property (@(posedge clk) reset_i |=> !rollback_i)
	else
	begin
		fail_count++;
		$error("Rollback raised during reset");
	end

endmodule

bind l2_store_path l2_store_path_assert u_l2_store_path_assert (
	.clk            (clk),
	.reset_i        (reset_i),
	.pci_valid_i    (pci_valid_o),
	.pci_ack_i      (pci_ack_i),
	.pci_strand_i   (pci_strand_o),
	.pci_op_i       (pci_op_o),
	.pci_address_i  (pci_address_o),
	.pci_data_i     (pci_data_o),
	.pci_mask_i     (pci_mask_o),
	.l2_done_mask_i (l2_done_mask),
	.entry_valid_i  (u_store_buffer.entry_valid),
	.rollback_i     (rollback_o)
);

// File: verif/l2_store_path_tb.sv
// Testbench for the store path: drives L1 operations, models the L2 and checks results.
// Run with the file list; the bound assertion module is compiled alongside.

`timescale 1ns/10ps

`include "stbuf_settings.svh"

module l2_store_path_tb;

	import stbuf_pkg::*;

	logic         clk;
	logic         reset_i;
	logic         dcache_store_i;
	logic         dcache_flush_i;
	logic         dcache_stbar_i;
	logic         synchronized_i;
	strand_t      strand_i;
	l1_tag_t      requested_tag_i;
	l1_set_t      requested_set_i;
	line_data_t   store_data_i;
	line_mask_t   store_mask_i;
	line_data_t   data_o;
	line_mask_t   mask_o;
	logic         rollback_o;
	strand_mask_t store_resume_strands_o;
	logic         store_update_o;
	l1_set_t      store_update_set_o;
	logic         pci_valid_o;
	logic         pci_ack_i;
	strand_t      pci_strand_o;
	l2_op_t       pci_op_o;
	logic [`STBUF_TAG_WIDTH+`STBUF_SET_WIDTH-1:0] pci_address_o;
	line_data_t   pci_data_o;
	line_mask_t   pci_mask_o;
	logic         cpi_valid_i;
	unit_t        cpi_unit_i;
	strand_t      cpi_strand_i;
	logic         cpi_status_i;
	logic         cpi_update_i;

	// Reference view of the store buffer, one slot per strand
	logic         ref_valid [`STBUF_STRANDS];
	logic         ref_pending [`STBUF_STRANDS];
	logic         ref_wait [`STBUF_STRANDS];
	logic         ref_sync_wait [`STBUF_STRANDS];
	logic         ref_sync_done [`STBUF_STRANDS];
	logic         ref_sync_status [`STBUF_STRANDS];
	l1_tag_t      ref_tag [`STBUF_STRANDS];
	l1_set_t      ref_set [`STBUF_STRANDS];
	line_data_t   ref_data [`STBUF_STRANDS];
	line_mask_t   ref_mask [`STBUF_STRANDS];
	l2_op_t       ref_op [`STBUF_STRANDS];

	logic [31:0]  rng_state = 32'd32;
	int           error_count = 0;
	int           check_count = 0;
	int           total_errors;

	l2_store_path DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		#500000;
		$display("Simulation ran past its time limit");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic line_data_t random_line();
		line_data_t line;
		for (int k = 0; k < `STBUF_LINE_BITS / 32; k++)
			line[k*32 +: 32] = xorshift32();
		return line;
	endfunction

	// What a load should see: only its own strand's entry at the same line
	function automatic line_data_t ref_bypass_data(strand_t s, l1_tag_t t, l1_set_t st);
		if (ref_valid[s] && ref_tag[s] == t && ref_set[s] == st)
			return ref_data[s];
		return '0;
	endfunction

	function automatic line_mask_t ref_bypass_mask(strand_t s, l1_tag_t t, l1_set_t st);
		if (ref_valid[s] && ref_tag[s] == t && ref_set[s] == st)
			return ref_mask[s];
		return '0;
	endfunction

	function automatic line_data_t ref_sync_line(logic status);
		line_data_t line;
		line = '0;
		for (int k = 0; k < `STBUF_LINE_BITS / 32; k++)
			line[k*32] = status;
		return line;
	endfunction

	task automatic check_line(input string name, input line_data_t exp, input line_data_t act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input line_mask_t exp, input line_mask_t act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_op(input string name, input l2_op_t exp, input l2_op_t act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_strands(input string name, input strand_mask_t exp,
		input strand_mask_t act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_set(input string name, input l1_set_t exp, input l1_set_t act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_tag(input string name, input l1_tag_t exp, input l1_tag_t act);
		check_count++;
		if (exp !== act)
		begin
			error_count++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Compares each accepted request and each response against the reference
	always @(posedge clk)
	begin : compare_bus
		strand_t s;
		if (!reset_i && pci_valid_o && pci_ack_i)
		begin
			s = pci_strand_o;
			if (!ref_pending[s])
			begin
				error_count++;
				$display("L2 request issued for strand %0d with nothing pending", s);
			end
			else
			begin
				ref_pending[s] = 1'b0;
				check_op("issue op", ref_op[s], pci_op_o);
				check_set("issue set", ref_set[s], pci_address_o[`STBUF_SET_WIDTH-1:0]);
				check_tag("issue tag", ref_tag[s],
					pci_address_o[`STBUF_TAG_WIDTH+`STBUF_SET_WIDTH-1:`STBUF_SET_WIDTH]);
				check_line("issue data", ref_data[s], pci_data_o);
				check_mask("issue mask", ref_mask[s], pci_mask_o);
			end
		end
		if (!reset_i && cpi_valid_i)
		begin
			// Responses addressed to other units never update this cache
			check_bit("store update", cpi_unit_i == STBUF_UNIT && cpi_update_i,
				store_update_o);
			if (cpi_unit_i == STBUF_UNIT && cpi_update_i)
				check_set("update set", ref_set[cpi_strand_i], store_update_set_o);
		end
	end

	// Every task below starts and ends on a falling edge
	task automatic store_op(input strand_t s, input logic flush, input logic sync);
		l1_tag_t    tag;
		l1_set_t    set;
		line_data_t data;
		line_mask_t mask;
		logic       exp_rollback;
		logic       enq;
		tag = l1_tag_t'(xorshift32());
		set = l1_set_t'(xorshift32());
		data = random_line();
		mask = {xorshift32(), xorshift32()};
		exp_rollback = ref_valid[s] || (sync && !ref_sync_done[s]);
		enq = !ref_valid[s] && (!sync || !ref_sync_done[s]);
		dcache_store_i = !flush;
		dcache_flush_i = flush;
		synchronized_i = sync;
		strand_i = s;
		requested_tag_i = tag;
		requested_set_i = set;
		store_data_i = data;
		store_mask_i = mask;
		@(negedge clk);
		dcache_store_i = 1'b0;
		dcache_flush_i = 1'b0;
		synchronized_i = 1'b0;
		check_bit("rollback", exp_rollback, rollback_o);
		if (ref_valid[s])
			ref_wait[s] = 1'b1;
		else if (sync && !ref_sync_done[s])
			ref_sync_wait[s] = 1'b1;
		else if (sync)
		begin
			// The retry returns the saved status instead of going to the L2
			check_mask("sync mask", '1, mask_o);
			check_line("sync status", ref_sync_line(ref_sync_status[s]), data_o);
			ref_sync_done[s] = 1'b0;
		end
		if (enq)
		begin
			ref_valid[s] = 1'b1;
			ref_pending[s] = 1'b1;
			ref_tag[s] = tag;
			ref_set[s] = set;
			ref_data[s] = data;
			ref_mask[s] = mask;
			ref_op[s] = flush ? L2_OP_FLUSH : (sync ? L2_OP_STORE_SYNC : L2_OP_STORE);
		end
	endtask

	task automatic load_check(input strand_t s, input l1_tag_t tag, input l1_set_t set);
		strand_i = s;
		requested_tag_i = tag;
		requested_set_i = set;
		@(negedge clk);
		check_line("load data", ref_bypass_data(s, tag, set), data_o);
		check_mask("load mask", ref_bypass_mask(s, tag, set), mask_o);
	endtask

	// L2 side: accept one request after a random stall
	task automatic issue_ack();
		int cycles;
		int delay;
		cycles = 0;
		while (!pci_valid_o && cycles < 64)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!pci_valid_o)
		begin
			error_count++;
			$display("Timed out waiting for an L2 request");
		end
		else
		begin
			delay = xorshift32() % 4;
			repeat (delay) @(negedge clk);
			pci_ack_i = 1'b1;
			@(negedge clk);
			pci_ack_i = 1'b0;
		end
	endtask

	task automatic respond(input strand_t s, input logic status, input logic update);
		strand_mask_t exp_resume;
		exp_resume = '0;
		exp_resume[s] = ref_wait[s] || ref_sync_wait[s];
		cpi_valid_i = 1'b1;
		cpi_unit_i = STBUF_UNIT;
		cpi_strand_i = s;
		cpi_status_i = status;
		cpi_update_i = update;
		@(negedge clk);
		cpi_valid_i = 1'b0;
		check_strands("resume", exp_resume, store_resume_strands_o);
		if (ref_sync_wait[s])
		begin
			ref_sync_done[s] = 1'b1;
			ref_sync_status[s] = status;
		end
		ref_valid[s] = 1'b0;
		ref_wait[s] = 1'b0;
		ref_sync_wait[s] = 1'b0;
	endtask

	// A response for another unit leaves entries and waiting strands alone
	task automatic foreign_response(input strand_t s);
		cpi_valid_i = 1'b1;
		cpi_unit_i = unit_t'(STBUF_UNIT + 1);
		cpi_strand_i = s;
		cpi_status_i = 1'b1;
		cpi_update_i = 1'b1;
		@(negedge clk);
		cpi_valid_i = 1'b0;
		check_strands("foreign resume", '0, store_resume_strands_o);
	endtask

	initial
	begin
		reset_i = 1'b1;
		dcache_store_i = 1'b0;
		dcache_flush_i = 1'b0;
		dcache_stbar_i = 1'b0;
		synchronized_i = 1'b0;
		strand_i = '0;
		requested_tag_i = '0;
		requested_set_i = '0;
		store_data_i = '0;
		store_mask_i = '0;
		pci_ack_i = 1'b0;
		cpi_valid_i = 1'b0;
		cpi_unit_i = '0;
		cpi_strand_i = '0;
		cpi_status_i = 1'b0;
		cpi_update_i = 1'b0;
		for (int i = 0; i < `STBUF_STRANDS; i++)
		begin
			ref_valid[i] = 1'b0;
			ref_pending[i] = 1'b0;
			ref_wait[i] = 1'b0;
			ref_sync_wait[i] = 1'b0;
			ref_sync_done[i] = 1'b0;
			ref_sync_status[i] = 1'b0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		@(negedge clk);

		// Plain stores from every strand, then bypass from own and other lines
		for (int s = 0; s < `STBUF_STRANDS; s++)
			store_op(strand_t'(s), 1'b0, 1'b0);
		for (int s = 0; s < `STBUF_STRANDS; s++)
		begin
			load_check(strand_t'(s), ref_tag[s], ref_set[s]);
			load_check(strand_t'(s), ref_tag[s] ^ l1_tag_t'(1), ref_set[s]);
			load_check(strand_t'(s + 1), ref_tag[s], ref_set[s]);
		end
		repeat (`STBUF_STRANDS) issue_ack();
		for (int s = 0; s < `STBUF_STRANDS; s++)
			respond(strand_t'(s), xorshift32() % 2, xorshift32() % 2);

		// Busy strand rolls back and resumes on its response
		store_op(1, 1'b0, 1'b0);
		store_op(1, 1'b0, 1'b0);
		issue_ack();
		foreign_response(1);
		respond(1, 1'b0, 1'b1);

		store_op(2, 1'b1, 1'b0);
		issue_ack();
		respond(2, 1'b0, 1'b0);

		// Sync store: first attempt goes to the L2, retry completes locally
		store_op(3, 1'b0, 1'b1);
		issue_ack();
		respond(3, xorshift32() % 2, 1'b1);
		store_op(3, 1'b0, 1'b1);
		repeat (4) @(negedge clk);
		check_bit("no request after sync retry", 1'b0, pci_valid_o);

		total_errors = error_count + DUT.u_l2_store_path_assert.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
			error_count, DUT.u_l2_store_path_assert.fail_count);
		if (total_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: l2_store_path.f
+incdir+verilog
verilog/stbuf_pkg.sv
verilog/issue_arbiter.sv
verilog/l2_request_port.sv
verilog/sync_store_tracker.sv
verilog/store_buffer.sv
verilog/l2_store_path.sv
verif/l2_store_path_assert.sv
verif/l2_store_path_tb.sv

// File: Bender.yml
package:
  name: l2_store_path

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/stbuf_pkg.sv
      - verilog/issue_arbiter.sv
      - verilog/l2_request_port.sv
      - verilog/sync_store_tracker.sv
      - verilog/store_buffer.sv
      - verilog/l2_store_path.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/l2_store_path_assert.sv
      - verif/l2_store_path_tb.sv
